//--- motor_regs.f
+incdir+include
verilog/motor_regs_pkg.sv
verilog/drive_channel.sv
verilog/rotation_channel.sv
verilog/motor_regs.sv
tests/motor_regs_tb.sv

//--- Makefile
# Verilator build and self-check run of the motor register block

VERILATOR ?= verilator
TOP       ?= motor_regs_tb
FILELIST  ?= motor_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/motor_regs_tb.sv
// Motor register block testbench
// Drives the host bus, keeps a register model, asserts outputs and readback

`timescale 1ns/1ps

`include "motor_regs_config.svh"

module motor_regs_tb
    import motor_regs_pkg::*;
();

    localparam int PULSE_TIMEOUT = 20;     // Cycles allowed for a command pulse
    localparam int RUN_LIMIT_NS  = 100000;

    logic          clock;
    logic          arst_n;
    reg_addr_t     address;
    logic          write_en;
    logic          read_en;
    reg_data_t     wr_data;
    reg_data_t     rd_data;
    drive_ctrl_t   drive_ctrl   [`MR_NUM_DRIVE];
    drive_status_t drive_status [`MR_NUM_DRIVE];
    rot_ctrl_t     rot_ctrl     [`MR_NUM_ROT];
    rot_sense_t    rot_sense    [`MR_NUM_ROT];
    rot_cmd_t      rot_cmd      [`MR_NUM_ROT];

    // One model byte per writable register
    reg_data_t drv_m  [`MR_NUM_DRIVE];
    reg_data_t ctl_m  [`MR_NUM_ROT];
    reg_data_t tgt_m  [`MR_NUM_ROT];
    reg_data_t kp_m   [`MR_NUM_ROT];
    reg_data_t kikd_m [`MR_NUM_ROT];
    reg_data_t ovrd_m [`MR_NUM_ROT];

    int checks;
    int errors;
    int tests;
    int errors_mark;                       // Errors before the current test

    motor_regs DUT (
        .clock        (clock),
        .arst_n       (arst_n),
        .address      (address),
        .write_en     (write_en),
        .read_en      (read_en),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .drive_ctrl   (drive_ctrl),
        .drive_status (drive_status),
        .rot_ctrl     (rot_ctrl),
        .rot_sense    (rot_sense),
        .rot_cmd      (rot_cmd)
    );

    always #10 clock = ~clock;             // 20 ns period

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got == exp) else begin
            $display("mismatch %s exp %0h got %0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-9s done, %0d errors", name, errors - errors_mark);
        errors_mark = errors;
    endtask

    task automatic wait_cycles(input int n);
        for (int k = 0; k < n; k++)
            @(negedge clock);
    endtask

    function automatic reg_addr_t drive_addr(input int i, input int status);
        return reg_addr_t'(`MR_DRIVE_BASE + 2 * i + status);   // Status is odd
    endfunction

    function automatic reg_addr_t rot_addr(input int j, input int ofs);
        return reg_addr_t'(`MR_ROT_BASE + `MR_ROT_STRIDE * j + ofs);
    endfunction

    // Held across one rising edge, dropped on the next falling edge
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clock);
        address  = addr;
        wr_data  = data;
        write_en = 1'b1;
        @(negedge clock);
        write_en = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        @(negedge clock);
        address = addr;
        read_en = 1'b1;
        @(negedge clock);                  // One-cycle latency
        read_en = 1'b0;
        data    = rd_data;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t got;
        bus_read(addr, got);
        check_equal(name, 64'(exp), 64'(got));
    endtask

    task automatic check_drive_outputs();
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            check_equal($sformatf("drive_ctrl[%0d]", i), 64'(drv_m[i]),
                        64'({drive_ctrl[i].brake, drive_ctrl[i].enable,
                             drive_ctrl[i].direction, drive_ctrl[i].duty}));
    endtask

    task automatic check_rot_outputs();
        logic [38:0] exp;
        logic [38:0] got;
        for (int j = 0; j < `MR_NUM_ROT; j++) begin
            // Bit 4 of control is not stored
            exp = {ctl_m[j][7:5], ctl_m[j][3:0], tgt_m[j], kp_m[j], kikd_m[j], ovrd_m[j]};
            got = {rot_ctrl[j].calib_en, rot_ctrl[j].enable, rot_ctrl[j].stall_chk_en,
                   rot_ctrl[j].target_angle, rot_ctrl[j].kp, rot_ctrl[j].ki, rot_ctrl[j].kd,
                   rot_ctrl[j].ovrd_en, rot_ctrl[j].ovrd_dir, rot_ctrl[j].ovrd_ratio};
            check_equal($sformatf("rot_ctrl[%0d]", j), 64'(exp), 64'(got));
        end
    endtask

    function automatic logic pulse_level(input int j, input logic abort);
        return abort ? rot_cmd[j].abort_angle : rot_cmd[j].update_angle;
    endfunction

    // Falling edges until the pulse rises, then how many it stays high
    task automatic measure_pulse(input int j, input logic abort, output int delay,
                                 output int width);
        delay = 0;
        width = 0;
        while (!pulse_level(j, abort) && delay < PULSE_TIMEOUT) begin
            @(negedge clock);
            delay++;
        end
        while (pulse_level(j, abort) && width < PULSE_TIMEOUT) begin
            width++;
            @(negedge clock);
        end
    endtask

    initial begin
        #(RUN_LIMIT_NS);
        $display("error: simulation time limit reached, a wait did not complete");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reg_data_t b;
        logic      sf;
        logic      done;
        angle_t    angle;
        int        delay;
        int        width;
        void'($urandom(32'hf9b1ca63));
        clock    = 1'b0;
        arst_n   = 1'b0;
        address  = '0;
        write_en = 1'b0;
        read_en  = 1'b0;
        wr_data  = '0;
        for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
            drive_status[i] = '0;
            drv_m[i]        = '0;
        end
        for (int j = 0; j < `MR_NUM_ROT; j++) begin
            rot_sense[j] = '0;
            ctl_m[j]     = '0;
            tgt_m[j]     = '0;
            kp_m[j]      = '0;
            kikd_m[j]    = '0;
            ovrd_m[j]    = '0;
        end
        wait_cycles(2);                    // Two rising edges in reset
        arst_n = 1'b1;
        wait_cycles(1);

        // Reset values and unmapped reads
        check_drive_outputs();
        check_rot_outputs();
        for (int j = 0; j < `MR_NUM_ROT; j++)
            check_equal($sformatf("rot_cmd[%0d]", j), 64'(0), 64'(rot_cmd[j]));
        check_equal("rd_data", 64'(0), 64'(rd_data));
        read_check(6'h00, 8'h00, "rd_data @00");
        read_check(6'h02, 8'h00, "rd_data @02");
        read_check(6'h2A, 8'h00, "rd_data @2a");
        end_test("reset");

        for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
            b        = reg_data_t'($urandom);
            drv_m[i] = b;
            bus_write(drive_addr(i, 0), b);
            check_drive_outputs();             // Others must not move
            read_check(drive_addr(i, 0), b, $sformatf("drive ctrl rd[%0d]", i));
        end
        end_test("drive");

        // Both broadcast aliases hit all drive channels
        b = reg_data_t'($urandom);
        bus_write(`MR_BCAST_ALL, b);
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            drv_m[i] = b;
        check_drive_outputs();
        b = reg_data_t'($urandom);
        bus_write(`MR_BCAST_DRIVE, b);
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            drv_m[i] = b;
        check_drive_outputs();
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            read_check(drive_addr(i, 0), b, $sformatf("bcast rd[%0d]", i));
        end_test("broadcast");

        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            drive_status[i] = drive_status_t'($urandom);
        wait_cycles(2);                    // Status lags one edge
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            read_check(drive_addr(i, 1), {drive_status[i].fault, drive_status[i].startup_fail,
                       drive_status[i].temp}, $sformatf("drive status rd[%0d]", i));
        end_test("status");

        for (int j = 0; j < `MR_NUM_ROT; j++) begin
            sf                        = 1'($urandom);
            rot_sense[j].startup_fail = sf;
            b        = reg_data_t'($urandom);
            b[4]     = ~sf;                // Written bit 4 must be ignored
            ctl_m[j] = b;
            bus_write(rot_addr(j, `MR_ROT_OFS_CTRL), b);
            tgt_m[j]  = reg_data_t'($urandom);
            kp_m[j]   = reg_data_t'($urandom);
            kikd_m[j] = reg_data_t'($urandom);
            ovrd_m[j] = reg_data_t'($urandom);
            bus_write(rot_addr(j, `MR_ROT_OFS_TGT_LO), tgt_m[j]);
            bus_write(rot_addr(j, `MR_ROT_OFS_KP), kp_m[j]);
            bus_write(rot_addr(j, `MR_ROT_OFS_KIKD), kikd_m[j]);
            bus_write(rot_addr(j, `MR_ROT_OFS_OVRD), ovrd_m[j]);
            check_rot_outputs();
            read_check(rot_addr(j, `MR_ROT_OFS_CTRL), {b[7:5], sf, b[3:0]}, "rot ctrl rd");
            read_check(rot_addr(j, `MR_ROT_OFS_TGT_LO), tgt_m[j], "rot tgt rd");
            read_check(rot_addr(j, `MR_ROT_OFS_KP), kp_m[j], "rot kp rd");
            read_check(rot_addr(j, `MR_ROT_OFS_KIKD), kikd_m[j], "rot kikd rd");
            read_check(rot_addr(j, `MR_ROT_OFS_OVRD), ovrd_m[j], "rot ovrd rd");
        end
        end_test("rotation");

        for (int j = 0; j < `MR_NUM_ROT; j++) begin
            angle                      = angle_t'($urandom);
            done                       = 1'($urandom);
            rot_sense[j].current_angle = angle;
            rot_sense[j].angle_done    = done;
            wait_cycles(2);
            bus_write(rot_addr(j, `MR_ROT_OFS_ANG_HI), 8'h40);  // Snapshot only
            check_equal("rot_cmd after snapshot", 64'(0), 64'(rot_cmd[j]));
            rot_sense[j].current_angle = ~angle;  // Snapshot must hold
            wait_cycles(2);
            read_check(rot_addr(j, `MR_ROT_OFS_ANG_LO), angle[7:0], "angle lo rd");
            read_check(rot_addr(j, `MR_ROT_OFS_ANG_HI), {done, 3'b000, angle[11:8]},
                       "angle hi rd");
            bus_write(rot_addr(j, `MR_ROT_OFS_ANG_HI), 8'h20);
            check_equal("abort_angle", 64'(0), 64'(rot_cmd[j].abort_angle));
            measure_pulse(j, 1'b0, delay, width);
            check_true(delay < PULSE_TIMEOUT, "update_angle never rose");
            check_equal("update_angle delay", 64'(0), 64'(delay));
            check_equal("update_angle width", 64'(1), 64'(width));
            bus_write(rot_addr(j, `MR_ROT_OFS_ANG_HI), 8'h10);
            check_equal("update_angle", 64'(0), 64'(rot_cmd[j].update_angle));
            measure_pulse(j, 1'b1, delay, width);
            check_true(delay < PULSE_TIMEOUT, "abort_angle never rose");
            check_equal("abort_angle delay", 64'(0), 64'(delay));
            check_equal("abort_angle width", 64'(1), 64'(width));
        end
        end_test("snapshot");

        // Unmapped addresses again while every register holds data
        read_check(6'h00, 8'h00, "rd_data @00");
        read_check(6'h02, 8'h00, "rd_data @02");
        for (int a = 'h28; a < 64; a++)
            read_check(reg_addr_t'(a), 8'h00, $sformatf("rd_data @%0h", a));
        end_test("unmapped");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog/motor_regs.sv
// Swerve robot motor register block
// Host register bus with drive and rotation channel arrays and a registered read port

`timescale 1ns/1ps

`include "motor_regs_config.svh"

module motor_regs
    import motor_regs_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  reg_addr_t     address,
    input  logic          write_en,
    input  logic          read_en,
    input  reg_data_t     wr_data,
    output reg_data_t     rd_data,
    output drive_ctrl_t   drive_ctrl   [`MR_NUM_DRIVE],
    input  drive_status_t drive_status [`MR_NUM_DRIVE],
    output rot_ctrl_t     rot_ctrl     [`MR_NUM_ROT],
    input  rot_sense_t    rot_sense    [`MR_NUM_ROT],
    output rot_cmd_t      rot_cmd      [`MR_NUM_ROT]
);

    host_bus_t bus;
    reg_data_t drive_rd [`MR_NUM_DRIVE];  // Per-channel read bytes
    reg_data_t rot_rd   [`MR_NUM_ROT];
    reg_data_t rd_next;

    // Same bus to every channel
    assign bus.address  = address;
    assign bus.write_en = write_en;
    assign bus.wr_data  = wr_data;

    for (genvar i = 0; i < `MR_NUM_DRIVE; i++) begin : g_drive
        drive_channel #(
            .CHANNEL (i)
        ) u_drive (
            .clock     (clock),
            .arst_n    (arst_n),
            .bus       (bus),
            .status_in (drive_status[i]),
            .ctrl      (drive_ctrl[i]),
            .rd_byte   (drive_rd[i])
        );
    end

    for (genvar j = 0; j < `MR_NUM_ROT; j++) begin : g_rot
        rotation_channel #(
            .CHANNEL (j)
        ) u_rot (
            .clock   (clock),
            .arst_n  (arst_n),
            .bus     (bus),
            .sense   (rot_sense[j]),
            .ctrl    (rot_ctrl[j]),
            .cmd     (rot_cmd[j]),
            .rd_byte (rot_rd[j])
        );
    end

    // Unaddressed channels give zero, so OR is the mux
    // Unmapped addresses therefore read as zero
    always_comb begin
        rd_next = '0;
        for (int i = 0; i < `MR_NUM_DRIVE; i++)
            rd_next = rd_next | drive_rd[i];
        for (int j = 0; j < `MR_NUM_ROT; j++)
            rd_next = rd_next | rot_rd[j];
    end

    // One-cycle read, holds when idle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            rd_data <= '0;
        else if (read_en)
            rd_data <= rd_next; // Pre-edge contents
    end

endmodule

//--- verilog/rotation_channel.sv
// Swerve rotation channel
// Control, target angle, PID gains, PWM override, angle snapshot and commands

`timescale 1ns/1ps

`include "motor_regs_config.svh"

module rotation_channel
    import motor_regs_pkg::*;
#(
    parameter int CHANNEL = 0
) (
    input  logic       clock,
    input  logic       arst_n,
    input  host_bus_t  bus,
    input  rot_sense_t sense,
    output rot_ctrl_t  ctrl,
    output rot_cmd_t   cmd,
    output reg_data_t  rd_byte
);

    localparam reg_addr_t BASE_ADDR = reg_addr_t'(`MR_ROT_BASE + `MR_ROT_STRIDE * CHANNEL);
    localparam reg_addr_t LAST_ADDR = reg_addr_t'(BASE_ADDR + `MR_ROT_STRIDE - 1);

    logic       in_range;
    reg_addr_t  ofs;
    logic [6:0] ctrl_q;    // calib, enable, stall check, target[11:8]
    reg_data_t  tgt_lo_q;
    gain_t      kp_q;
    reg_data_t  kikd_q;    // Ki high nibble, Kd low nibble
    reg_data_t  ovrd_q;
    angle_t     snap_q;    // Held copy so both angle bytes agree
    logic       done_q;
    logic       cmd_wr;

    assign in_range = (bus.address >= BASE_ADDR) && (bus.address <= LAST_ADDR);
    assign ofs      = bus.address - BASE_ADDR;
    assign cmd_wr   = bus.write_en && in_range && (ofs == `MR_ROT_OFS_ANG_HI);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            tgt_lo_q <= '0;
            kp_q     <= '0;
            kikd_q   <= '0;
            ovrd_q   <= '0;
            snap_q   <= '0;
            done_q   <= 1'b0;
            cmd      <= '0;
        end else begin
            if (bus.write_en && in_range) begin
                case (ofs)
                    `MR_ROT_OFS_CTRL:   ctrl_q   <= {bus.wr_data[7:5], bus.wr_data[3:0]};
                    `MR_ROT_OFS_TGT_LO: tgt_lo_q <= bus.wr_data;
                    `MR_ROT_OFS_KP:     kp_q     <= bus.wr_data;
                    `MR_ROT_OFS_KIKD:   kikd_q   <= bus.wr_data;
                    `MR_ROT_OFS_OVRD:   ovrd_q   <= bus.wr_data;
                    default: ;                        // Angle bytes are not writable
                endcase
            end
            if (cmd_wr && bus.wr_data[6])
                snap_q <= sense.current_angle;        // Capture on request
            done_q <= sense.angle_done;
            // One-cycle pulses after the command write
            cmd.update_angle <= cmd_wr && bus.wr_data[5];
            cmd.abort_angle  <= cmd_wr && bus.wr_data[4];
        end
    end

    always_comb begin
        ctrl.calib_en     = ctrl_q[6];
        ctrl.enable       = ctrl_q[5];
        ctrl.stall_chk_en = ctrl_q[4];
        ctrl.target_angle = {ctrl_q[3:0], tgt_lo_q};
        ctrl.kp           = kp_q;
        ctrl.ki           = kikd_q[7:4];
        ctrl.kd           = kikd_q[3:0];
        ctrl.ovrd_en      = ovrd_q[7];
        ctrl.ovrd_dir     = ovrd_q[6];
        ctrl.ovrd_ratio   = ovrd_q[5:0];
    end

    // Readback, zero outside this group
    always_comb begin
        rd_byte = '0;
        if (in_range) begin
            case (ofs)
                // Bit 4 shows this channel's own startup fail
                `MR_ROT_OFS_CTRL:   rd_byte = {ctrl_q[6:4], sense.startup_fail, ctrl_q[3:0]};
                `MR_ROT_OFS_TGT_LO: rd_byte = tgt_lo_q;
                `MR_ROT_OFS_ANG_LO: rd_byte = snap_q[7:0];
                `MR_ROT_OFS_ANG_HI: rd_byte = {done_q, 3'b000, snap_q[11:8]};
                `MR_ROT_OFS_KP:     rd_byte = kp_q;
                `MR_ROT_OFS_KIKD:   rd_byte = kikd_q;
                `MR_ROT_OFS_OVRD:   rd_byte = ovrd_q;
                default:            rd_byte = '0;
            endcase
        end
    end

endmodule

//--- verilog/drive_channel.sv
// Drive motor channel
// Control register with broadcast decode, sampled status register

`timescale 1ns/1ps

`include "motor_regs_config.svh"

module drive_channel
    import motor_regs_pkg::*;
#(
    parameter int CHANNEL = 0
) (
    input  logic          clock,
    input  logic          arst_n,
    input  host_bus_t     bus,
    input  drive_status_t status_in,
    output drive_ctrl_t   ctrl,
    output reg_data_t     rd_byte
);

    // Control at even address, status right after it
    localparam reg_addr_t CTRL_ADDR   = reg_addr_t'(`MR_DRIVE_BASE + 2 * CHANNEL);
    localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`MR_DRIVE_BASE + 2 * CHANNEL + 1);

    drive_status_t status_q;
    logic          ctrl_wr;

    // Own address or either broadcast
    assign ctrl_wr = bus.write_en &&
                     ((bus.address == CTRL_ADDR) ||
                      (bus.address == `MR_BCAST_ALL) ||
                      (bus.address == `MR_BCAST_DRIVE));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl     <= '0;
            status_q <= '0;
        end else begin
            if (ctrl_wr)
                ctrl <= drive_ctrl_t'(bus.wr_data); // Byte maps straight onto fields
            status_q <= status_in;                  // Resampled every edge
        end
    end

    // Zero when not addressed so the top can OR channels together
    always_comb begin
        if (bus.address == CTRL_ADDR)
            rd_byte = reg_data_t'(ctrl);
        else if (bus.address == STATUS_ADDR)
            rd_byte = reg_data_t'(status_q);
        else
            rd_byte = '0;
    end

endmodule

//--- verilog/motor_regs_pkg.sv
// Motor register types
// Vector typedefs and structs shared by the register block and its testbench

`include "motor_regs_config.svh"

package motor_regs_pkg;

    typedef logic [`MR_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`MR_DATA_W-1:0]  reg_data_t;
    typedef logic [`MR_ANGLE_W-1:0] angle_t;
    typedef logic [`MR_PWM_W-1:0]   pwm_duty_t;
    typedef logic [`MR_TEMP_W-1:0]  adc_temp_t;
    typedef logic [`MR_OVRD_W-1:0]  ovrd_ratio_t;
    typedef logic [7:0]             gain_t;      // Kp, fixed point 4.4
    typedef logic [3:0]             gain_frac_t; // Ki or Kd, fixed point 0.4

    typedef struct packed {
        reg_addr_t address;
        logic      write_en;
        reg_data_t wr_data;
    } host_bus_t;

    // Same layout as the drive control byte
    typedef struct packed {
        logic      brake;
        logic      enable;
        logic      direction;
        pwm_duty_t duty;
    } drive_ctrl_t;

    // Same layout as the drive status byte
    typedef struct packed {
        logic      fault;
        logic      startup_fail;
        adc_temp_t temp;
    } drive_status_t;

    typedef struct packed {
        logic        calib_en;     // I2C calibration override
        logic        enable;
        logic        stall_chk_en;
        angle_t      target_angle;
        gain_t       kp;
        gain_frac_t  ki;
        gain_frac_t  kd;
        logic        ovrd_en;      // PWM override
        logic        ovrd_dir;
        ovrd_ratio_t ovrd_ratio;
    } rot_ctrl_t;

    typedef struct packed {
        angle_t current_angle;
        logic   angle_done;
        logic   startup_fail;
    } rot_sense_t;

    typedef struct packed {
        logic update_angle;
        logic abort_angle;
    } rot_cmd_t;

endpackage

//--- include/motor_regs_config.svh
// Motor register block configuration
// Channel counts, field widths and the host register address map

`ifndef MOTOR_REGS_CONFIG_SVH
`define MOTOR_REGS_CONFIG_SVH

// Host bus
`define MR_ADDR_W        6
`define MR_DATA_W        8

`define MR_NUM_DRIVE     4     // Swerve drive motors
`define MR_NUM_ROT       4     // Swerve rotation motors

// Field widths
`define MR_ANGLE_W       12
`define MR_PWM_W         5
`define MR_TEMP_W        6
`define MR_OVRD_W        6

// Address map
`define MR_BCAST_ALL     6'h01 // Every drive control register
`define MR_BCAST_DRIVE   6'h03 // Same effect, drive-only alias
`define MR_DRIVE_BASE    6'h04 // Control then status, two per channel
`define MR_ROT_BASE      6'h0C
`define MR_ROT_STRIDE    7

// Offsets inside one rotation group
`define MR_ROT_OFS_CTRL   6'd0
`define MR_ROT_OFS_TGT_LO 6'd1
`define MR_ROT_OFS_ANG_LO 6'd2
`define MR_ROT_OFS_ANG_HI 6'd3 // Also the command register
`define MR_ROT_OFS_KP     6'd4
`define MR_ROT_OFS_KIKD   6'd5
`define MR_ROT_OFS_OVRD   6'd6

`endif
